/* run_sim.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

# Build the testbench with the bound assertions
verilator --binary --timing --assert -j 0 --top-module env_capture_tb \
    -f verilog.f -o env_capture_sim

# Run and keep the log
./obj_dir/env_capture_sim | tee sim.log

if grep -q "Simulation finished: PASS" sim.log; then
    exit 0
fi
exit 1

/* src/acq_if.sv */
`timescale 1ns/1ps

// Gated sample stream from the line gate to the envelope and tag logic
interface acq_if;
    import env_pkg::*;

    logic                    fill_en;    // Capture window open
    logic                    wen;        // Sample valid, only inside window
    logic [SAMPLE_IDX_W-1:0] sample_idx; // Position within the line
    adc_sample_t             sample;     // Raw ADC value

    // Line gate side
    modport gate (
        output fill_en,
        output wen,
        output sample_idx,
        output sample
    );

    // Consumers
    modport sink (
        input fill_en,
        input wen,
        input sample_idx,
        input sample
    );

endinterface

/* src/env_accum.sv */
`timescale 1ns/1ps

module env_accum (
    input  logic                            sys_clk,
    input  logic                            sys_rst,
    acq_if.sink                             acq,
    output logic                            env_valid, // One pulse per chunk
    output logic [env_pkg::ENV_DATA_W-1:0]  env_mean,  // Mean deviation
    output logic [env_pkg::BUFF_ADDR_W-1:0] env_chunk  // Chunk index
);
    import env_pkg::*;

    logic [ADC_DATA_W-2:0] low_bits;    // Sample without its top bit
    logic [ADC_DATA_W-2:0] dev;         // |sample - midrange|
    logic [ENV_SUM_W-1:0]  acc;         // Running chunk sum
    logic [ENV_SUM_W-1:0]  acc_next;
    logic                  chunk_first; // Index bits 4..0 all zero
    logic                  chunk_last;  // Index bits 4..0 all ones

    assign low_bits = acq.sample[ADC_DATA_W-2:0];
    // Upper half counts up from midrange, lower half counts down
    assign dev = acq.sample[ADC_DATA_W-1] ? low_bits
                                          : {(ADC_DATA_W-1){1'b1}} - low_bits;

    assign chunk_first = (acq.sample_idx[CHUNK_W-1:0] == '0);
    assign chunk_last  = &acq.sample_idx[CHUNK_W-1:0];

    // Load on the first sample of a chunk
    assign acc_next = chunk_first ? ENV_SUM_W'(dev) : acc + ENV_SUM_W'(dev);

    always_ff @(posedge sys_clk) begin
        if (acq.wen) begin
            acc <= acc_next;
        end
    end

    always_ff @(posedge sys_clk or posedge sys_rst) begin
        if (sys_rst) begin
            env_valid <= 1'b0;
        end else begin
            env_valid <= acq.wen && chunk_last;
        end
    end

    // Result includes the last sample of the chunk
    always_ff @(posedge sys_clk) begin
        if (acq.wen && chunk_last) begin
            env_mean  <= acc_next[ENV_SHIFT +: ENV_DATA_W];
            env_chunk <= acq.sample_idx[CHUNK_W +: BUFF_ADDR_W];
        end
    end

endmodule

/* src/env_capture_top.sv */
`timescale 1ns/1ps

module env_capture_top (
    input  logic                             sys_clk,
    input  logic                             sys_rst,
    // Acquisition stream
    input  logic                             acq_start,
    input  logic                             acq_wen,
    input  logic [env_pkg::SAMPLE_IDX_W-1:0] acq_waddr,
    input  env_pkg::adc_sample_t             acq_wdata,
    // DAC writes and TOP_TURN pins
    input  logic [env_pkg::DAC_DATA_W-1:0]   dac_din,
    input  logic                             dac_dvalid,
    input  logic [env_pkg::TOPTURN_N-1:0]    topturn,
    // Buffer readout
    input  logic                             buff_rd,
    input  logic [env_pkg::BUFF_ADDR_W-1:0]  buff_raddr,
    output logic                             fill_active,
    output logic                             buff_rvalid,
    output logic [env_pkg::BUFF_DATA_W-1:0]  buff_rdata
);
    import env_pkg::*;

    acq_if acq ();

    logic                   env_valid;
    logic [ENV_DATA_W-1:0]  env_mean;
    logic [BUFF_ADDR_W-1:0] env_chunk;
    logic [ENV_DATA_W-1:0]  gain_tag;
    logic [TOPTURN_N-1:0]   topturn_tag;
    logic                   wr;
    logic [BUFF_ADDR_W-1:0] waddr;
    env_word_t              wdata;

    //------------------------------------------------------------------------
    // Envelope path
    //------------------------------------------------------------------------
    line_gate u_line_gate (
        .sys_clk     (sys_clk),
        .sys_rst     (sys_rst),
        .acq_start   (acq_start),
        .acq_wen     (acq_wen),
        .acq_waddr   (acq_waddr),
        .acq_wdata   (acq_wdata),
        .fill_active (fill_active),
        .acq         (acq.gate)
    );

    env_accum u_env_accum (
        .sys_clk   (sys_clk),
        .sys_rst   (sys_rst),
        .acq       (acq.sink),
        .env_valid (env_valid),
        .env_mean  (env_mean),
        .env_chunk (env_chunk)
    );

    tag_sampler u_tag_sampler (
        .sys_clk     (sys_clk),
        .sys_rst     (sys_rst),
        .dac_din     (dac_din),
        .dac_dvalid  (dac_dvalid),
        .topturn     (topturn),
        .acq         (acq.sink),
        .gain_tag    (gain_tag),
        .topturn_tag (topturn_tag)
    );

    env_writer u_env_writer (
        .sys_clk     (sys_clk),
        .sys_rst     (sys_rst),
        .env_valid   (env_valid),
        .env_mean    (env_mean),
        .env_chunk   (env_chunk),
        .gain_tag    (gain_tag),
        .topturn_tag (topturn_tag),
        .wr          (wr),
        .waddr       (waddr),
        .wdata       (wdata)
    );

    // Readout runs on sys_clk too
    line_buffer u_line_buffer (
        .sys_clk (sys_clk),
        .sys_rst (sys_rst),
        .wr      (wr),
        .waddr   (waddr),
        .wdata   (wdata),
        .rd      (buff_rd),
        .raddr   (buff_raddr),
        .rdata   (buff_rdata),
        .rvalid  (buff_rvalid)
    );

endmodule

/* src/env_pkg.sv */
package env_pkg;

    //------------------------------------------------------------------------
    // Sample stream
    //------------------------------------------------------------------------
    localparam int ADC_DATA_W   = 10; // ADC sample width
    localparam int DAC_DATA_W   = 10; // DAC gain code width
    localparam int SAMPLE_IDX_W = 14; // 16384 samples per line

    //------------------------------------------------------------------------
    // Envelope and line buffer
    //------------------------------------------------------------------------
    localparam int CHUNK_W     = 5;  // 32 samples per envelope value
    localparam int BUFF_ADDR_W = 9;  // 512 words, one per chunk
    localparam int BUFF_DATA_W = 24; // Stored word width
    localparam int ENV_DATA_W  = 8;  // Envelope and gain tag width
    localparam int ENV_SUM_W   = 14; // 32 x 511 still fits
    // Mean over 32 plus one more bit for plot scale
    localparam int ENV_SHIFT   = 6;

    // Gain is sampled every 512 samples
    localparam int GAIN_PERIOD_W = 9;
    localparam int GAIN_SHIFT    = 2; // Drop DAC LSBs for the tag
    localparam int TOPTURN_N     = 3; // TOP_TURN inputs

    typedef logic [ADC_DATA_W-1:0] adc_sample_t;

    // One line buffer word, MSB first
    typedef struct packed {
        logic [4:0]            reserved; // Always zero
        logic [TOPTURN_N-1:0]  topturn;  // TOP_TURN at chunk start
        logic [ENV_DATA_W-1:0] gain;     // DAC gain in force
        logic [ENV_DATA_W-1:0] env;      // Envelope value
    } env_word_t;

endpackage

/* src/env_writer.sv */
`timescale 1ns/1ps

module env_writer (
    input  logic                            sys_clk,
    input  logic                            sys_rst,
    input  logic                            env_valid,   // Chunk done
    input  logic [env_pkg::ENV_DATA_W-1:0]  env_mean,    // Envelope value
    input  logic [env_pkg::BUFF_ADDR_W-1:0] env_chunk,   // Chunk index
    input  logic [env_pkg::ENV_DATA_W-1:0]  gain_tag,    // Current gain tag
    input  logic [env_pkg::TOPTURN_N-1:0]   topturn_tag, // Current TOP_TURN tag
    output logic                            wr,          // Buffer write strobe
    output logic [env_pkg::BUFF_ADDR_W-1:0] waddr,       // Buffer address
    output env_pkg::env_word_t              wdata        // Buffer word
);
    import env_pkg::*;

    env_word_t word_next; // Word being assembled

    // Pack envelope and tags
    always_comb begin
        word_next.reserved = '0;
        word_next.topturn  = topturn_tag;
        word_next.gain     = gain_tag;
        word_next.env      = env_mean;
    end

    //------------------------------------------------------------------------
    // Write stage
    //------------------------------------------------------------------------
    // One write per finished chunk
    always_ff @(posedge sys_clk or posedge sys_rst) begin
        if (sys_rst) begin
            wr <= 1'b0;
        end else begin
            wr <= env_valid;
        end
    end

    always_ff @(posedge sys_clk) begin
        if (env_valid) begin
            waddr <= env_chunk; // Chunk index is the address
            wdata <= word_next;
        end
    end

endmodule

/* src/line_buffer.sv */
`timescale 1ns/1ps

module line_buffer (
    input  logic                            sys_clk,
    input  logic                            sys_rst,
    input  logic                            wr,     // Write strobe
    input  logic [env_pkg::BUFF_ADDR_W-1:0] waddr,  // Write address
    input  env_pkg::env_word_t              wdata,  // Write word
    input  logic                            rd,     // Read request
    input  logic [env_pkg::BUFF_ADDR_W-1:0] raddr,  // Read address
    output logic [env_pkg::BUFF_DATA_W-1:0] rdata,  // Read word
    output logic                            rvalid  // Read word valid
);
    import env_pkg::*;

    logic [BUFF_DATA_W-1:0] mem [0:(1 << BUFF_ADDR_W)-1]; // 512 x 24

    // Single write port, registered read port
    always_ff @(posedge sys_clk) begin
        if (wr) begin
            mem[waddr] <= wdata;
        end
        if (rd) begin
            rdata <= mem[raddr];
        end
    end

    // Valid one cycle after the request
    always_ff @(posedge sys_clk or posedge sys_rst) begin
        if (sys_rst) begin
            rvalid <= 1'b0;
        end else begin
            rvalid <= rd;
        end
    end

endmodule

/* src/line_gate.sv */
`timescale 1ns/1ps

module line_gate (
    input  logic                             sys_clk,
    input  logic                             sys_rst,
    input  logic                             acq_start,   // Start of a new line
    input  logic                             acq_wen,     // Sample strobe from acquisition
    input  logic [env_pkg::SAMPLE_IDX_W-1:0] acq_waddr,   // Sample index
    input  env_pkg::adc_sample_t             acq_wdata,   // Sample value
    output logic                             fill_active, // Window open
    acq_if.gate                              acq
);

    logic line_end; // Sample 16383 is on the bus this cycle

    assign line_end = acq.wen && (&acq.sample_idx);

    //------------------------------------------------------------------------
    // Capture window
    //------------------------------------------------------------------------
    // Start pulse wins over the line end, so a restart keeps it open
    always_ff @(posedge sys_clk or posedge sys_rst) begin
        if (sys_rst) begin
            acq.fill_en <= 1'b0;
        end else if (acq_start) begin
            acq.fill_en <= 1'b1;
        end else if (line_end) begin
            acq.fill_en <= 1'b0; // Only the first line after start
        end
    end

    // Strobe passes only while the window is open
    always_ff @(posedge sys_clk or posedge sys_rst) begin
        if (sys_rst) begin
            acq.wen <= 1'b0;
        end else begin
            acq.wen <= acq_wen && acq.fill_en && !line_end;
        end
    end

    // Payload stage
    always_ff @(posedge sys_clk) begin
        if (acq_wen) begin
            acq.sample_idx <= acq_waddr;
            acq.sample     <= acq_wdata;
        end
    end

    assign fill_active = acq.fill_en;

endmodule

/* src/tag_sampler.sv */
`timescale 1ns/1ps

module tag_sampler (
    input  logic                           sys_clk,
    input  logic                           sys_rst,
    input  logic [env_pkg::DAC_DATA_W-1:0] dac_din,     // DAC code being written
    input  logic                           dac_dvalid,  // DAC write strobe
    input  logic [env_pkg::TOPTURN_N-1:0]  topturn,     // TOP_TURN pins
    acq_if.sink                            acq,
    output logic [env_pkg::ENV_DATA_W-1:0] gain_tag,    // Gain for this period
    output logic [env_pkg::TOPTURN_N-1:0]  topturn_tag  // TOP_TURN for this chunk
);
    import env_pkg::*;

    logic [DAC_DATA_W-1:0] dac_last;     // Last code sent to the DAC
    logic                  period_start; // Sample at a 512 boundary
    logic                  chunk_start;  // Sample at a 32 boundary

    assign period_start = acq.wen && (acq.sample_idx[GAIN_PERIOD_W-1:0] == '0);
    assign chunk_start  = acq.wen && (acq.sample_idx[CHUNK_W-1:0] == '0);

    //------------------------------------------------------------------------
    // DAC gain memory
    //------------------------------------------------------------------------
    always_ff @(posedge sys_clk or posedge sys_rst) begin
        if (sys_rst) begin
            dac_last <= '0;
        end else if (dac_dvalid) begin
            dac_last <= dac_din;
        end
    end

    //------------------------------------------------------------------------
    // Tags
    //------------------------------------------------------------------------
    // Gain only moves every 512 samples, so one tag covers 16 chunks
    always_ff @(posedge sys_clk or posedge sys_rst) begin
        if (sys_rst) begin
            gain_tag <= '0;
        end else if (!acq.fill_en) begin
            gain_tag <= '0;
        end else if (period_start) begin
            gain_tag <= dac_last[GAIN_SHIFT +: ENV_DATA_W];
        end
    end

    always_ff @(posedge sys_clk or posedge sys_rst) begin
        if (sys_rst) begin
            topturn_tag <= '0;
        end else if (!acq.fill_en) begin
            topturn_tag <= '0; // Idle between lines
        end else if (chunk_start) begin
            topturn_tag <= topturn;
        end
    end

endmodule

/* test/env_capture_props.sv */
`timescale 1ns/1ps

module env_capture_props (
    input logic sys_clk,
    input logic sys_rst,
    input logic rd,      // Buffer read request
    input logic rvalid,  // Buffer read data valid
    input logic wen,     // Gated sample strobe
    input logic fill_en  // Capture window
);

    //------------------------------------------------------------------------
    // Read port handshake
    //------------------------------------------------------------------------
    a_rvalid_after_rd: assert property (
        @(posedge sys_clk) disable iff (sys_rst) rd |=> rvalid
    ) else $error("rvalid missing one cycle after rd");

    a_rvalid_has_rd: assert property (
        @(posedge sys_clk) disable iff (sys_rst) rvalid |-> $past(rd)
    ) else $error("rvalid without a read request");

    // Samples only pass inside the window
    a_wen_in_window: assert property (
        @(posedge sys_clk) disable iff (sys_rst) wen |-> fill_en
    ) else $error("wen high with fill_en low");

endmodule

bind env_capture_top env_capture_props u_props (
    .sys_clk (sys_clk),
    .sys_rst (sys_rst),
    .rd      (buff_rd),
    .rvalid  (buff_rvalid),
    .wen     (acq.wen),
    .fill_en (acq.fill_en)
);

/* test/env_capture_tb.sv */
`timescale 1ns/1ps

module env_capture_tb;
    import env_pkg::*;

    // One row of the line table
    typedef struct packed {
        logic                  rnd;     // Random samples, else constant
        logic [ADC_DATA_W-1:0] value;   // Constant sample value
        logic [DAC_DATA_W-1:0] dac_pre; // DAC code written before the line
        logic                  dac_chg; // Second DAC write at sample 8192
        logic [DAC_DATA_W-1:0] dac_mid;
        logic [TOPTURN_N-1:0]  tt;      // TOP_TURN for the line
        logic                  start;   // Line is preceded by acq_start
        logic [ENV_DATA_W-1:0] env_exp; // Env field, constant rows only
    } line_case_t;

    localparam int N_CASES  = 6;
    localparam int LINE_LEN = 1 << SAMPLE_IDX_W;
    localparam int N_WORDS  = 1 << BUFF_ADDR_W;

    logic                    sys_clk;
    logic                    sys_rst;
    logic                    acq_start;
    logic                    acq_wen;
    logic [SAMPLE_IDX_W-1:0] acq_waddr;
    adc_sample_t             acq_wdata;
    logic [DAC_DATA_W-1:0]   dac_din;
    logic                    dac_dvalid;
    logic [TOPTURN_N-1:0]    topturn;
    logic                    buff_rd;
    logic [BUFF_ADDR_W-1:0]  buff_raddr;
    logic                    fill_active;
    logic                    buff_rvalid;
    logic [BUFF_DATA_W-1:0]  buff_rdata;

    line_case_t             cases [0:N_CASES-1];
    adc_sample_t            samp [0:LINE_LEN-1];    // Samples of the current line
    logic [BUFF_DATA_W-1:0] exp_mem [0:N_WORDS-1];  // Model of the line buffer
    logic [BUFF_DATA_W-1:0] rd_data;
    bit                     rd_ok;
    int                     seed;
    int                     test_err;  // Errors in the running test
    int                     err_cnt;
    int                     tests_pass;
    int                     tests_fail;

    env_capture_top dut (.*);

    initial sys_clk = 1'b0;
    always #20 sys_clk = ~sys_clk; // 40 ns period

    //------------------------------------------------------------------------
    // Helpers
    //------------------------------------------------------------------------
    // Inputs change 2 ns after the edge, outputs are settled by then
    task automatic tick();
        @(posedge sys_clk);
        #2;
    endtask

    function automatic line_case_t make_row(bit rnd, logic [9:0] value, logic [9:0] dac_pre,
                                            bit dac_chg, logic [9:0] dac_mid,
                                            logic [2:0] tt, bit start, logic [7:0] env_exp);
        return '{rnd, value, dac_pre, dac_chg, dac_mid, tt, start, env_exp};
    endfunction

    // Distance from midrange
    function automatic int mid_distance(adc_sample_t s);
        if (s[ADC_DATA_W-1]) begin
            return int'(s[ADC_DATA_W-2:0]);
        end
        return 511 - int'(s[ADC_DATA_W-2:0]);
    endfunction

    // Draw the samples and update the buffer model
    task automatic prepare_line(input line_case_t c);
        int                    i;
        int                    k;
        int                    r;
        int                    sum;
        logic [DAC_DATA_W-1:0] code;
        logic [ENV_DATA_W-1:0] env;
        for (i = 0; i < LINE_LEN; i++) begin
            if (c.rnd) begin
                r = $random(seed);
                samp[i] = r[ADC_DATA_W-1:0];
            end else begin
                samp[i] = c.value;
            end
        end
        if (c.start) begin // Unstarted lines leave the buffer alone
            for (k = 0; k < N_WORDS; k++) begin
                sum = 0;
                for (i = 0; i < 32; i++) begin
                    sum += mid_distance(samp[k * 32 + i]);
                end
                env  = c.rnd ? sum[ENV_SHIFT +: ENV_DATA_W] : c.env_exp; // Mean, halved
                code = (c.dac_chg && k >= N_WORDS / 2) ? c.dac_mid : c.dac_pre;
                exp_mem[k] = {5'b0, c.tt, code[GAIN_SHIFT +: ENV_DATA_W], env};
            end
        end
    endtask

    task automatic stream_line(input line_case_t c);
        int i;
        int r;
        bit seen;
        seen       = 1'b0;
        dac_din    = c.dac_pre;
        dac_dvalid = 1'b1;
        topturn    = c.tt;
        tick();
        dac_dvalid = 1'b0;
        if (c.start) begin
            acq_start = 1'b1;
            tick();
            acq_start = 1'b0;
        end
        for (i = 0; i < LINE_LEN; i++) begin
            if (c.rnd) begin
                r = $random(seed);
                if (r[2:0] == 3'd0) begin // Gap in the stream
                    acq_wen = 1'b0;
                    tick();
                end
            end
            acq_wen   = 1'b1;
            acq_waddr = i[SAMPLE_IDX_W-1:0];
            acq_wdata = samp[i];
            if (c.dac_chg && i == LINE_LEN / 2) begin
                dac_din    = c.dac_mid; // Gain change mid line
                dac_dvalid = 1'b1;
            end
            tick();
            dac_dvalid = 1'b0;
            if (!c.start && fill_active && !seen) begin
                $display("fill_active rose for a line sent without acq_start");
                test_err++;
                seen = 1'b1;
            end
        end
        acq_wen = 1'b0;
    endtask

    task automatic wait_line_end();
        int n;
        n = 0;
        while (fill_active && n < 64) begin
            tick();
            n++;
        end
        if (fill_active) begin
            $display("Timeout: fill_active did not fall after the last sample");
            test_err++;
        end
    endtask

    // One read; buff_rvalid must follow after exactly one cycle
    task automatic read_word(input int addr, output logic [BUFF_DATA_W-1:0] data,
                             output bit ok);
        int n;
        ok         = 1'b0;
        buff_rd    = 1'b1;
        buff_raddr = addr[BUFF_ADDR_W-1:0];
        tick();
        buff_rd = 1'b0;
        n = 1;
        while (!buff_rvalid && n < 8) begin
            tick();
            n++;
        end
        if (!buff_rvalid) begin
            $display("Timeout: buff_rvalid did not rise after the read of word %0d", addr);
            test_err++;
        end else if (n != 1) begin
            $display("buff_rvalid came %0d cycles after the read of word %0d", n, addr);
            test_err++;
        end else begin
            ok = 1'b1;
        end
        data = buff_rdata;
    endtask

    // Last words land a few cycles after fill_active falls, long before they are read
    task automatic check_line();
        int k;
        for (k = 0; k < N_WORDS; k++) begin
            read_word(k, rd_data, rd_ok);
            if (rd_ok && rd_data !== exp_mem[k]) begin
                $display("Error: buff_rdata[%0d] = %h, expected %h", k, rd_data, exp_mem[k]);
                test_err++;
            end
        end
    endtask

    task automatic report_test(input int num);
        if (test_err == 0) begin
            $display("Test %0d: ok", num);
            tests_pass++;
        end else begin
            $display("Test %0d: %0d errors", num, test_err);
            tests_fail++;
        end
        err_cnt += test_err;
    endtask

    //------------------------------------------------------------------------
    // Main sequence
    //------------------------------------------------------------------------
    initial begin
        int t;
        seed       = 32'h1acc;
        err_cnt    = 0;
        tests_pass = 0;
        tests_fail = 0;
        sys_rst    = 1'b1;
        acq_start  = 1'b0;
        acq_wen    = 1'b0;
        acq_waddr  = '0;
        acq_wdata  = '0;
        dac_din    = '0;
        dac_dvalid = 1'b0;
        topturn    = '0;
        buff_rd    = 1'b0;
        buff_raddr = '0;
        //            rnd   value   dac_pre  chg   dac_mid  tt      start env
        cases[0] = make_row(0, 10'h3ff, 10'h155, 0, 10'h000, 3'b101, 1, 8'hff);
        cases[1] = make_row(0, 10'h200, 10'h2a8, 0, 10'h000, 3'b010, 1, 8'h00);
        cases[2] = make_row(1, 10'h000, 10'h0f3, 0, 10'h000, 3'b111, 1, 8'h00);
        cases[3] = make_row(1, 10'h000, 10'h3c4, 1, 10'h01b, 3'b001, 1, 8'h00);
        cases[4] = make_row(0, 10'h000, 10'h200, 0, 10'h000, 3'b110, 0, 8'h00);
        cases[5] = make_row(0, 10'h100, 10'h3ff, 1, 10'h004, 3'b011, 1, 8'h7f);
        repeat (16) @(posedge sys_clk);
        #2;
        sys_rst = 1'b0;
        tick();

        // Idle state and read latency, contents still undefined
        test_err = 0;
        if (fill_active !== 1'b0) begin
            $display("Error: fill_active = %h, expected 0", fill_active);
            test_err++;
        end
        if (buff_rvalid !== 1'b0) begin
            $display("Error: buff_rvalid = %h, expected 0", buff_rvalid);
            test_err++;
        end
        read_word(0, rd_data, rd_ok);
        report_test(0);

        for (t = 0; t < N_CASES; t++) begin
            test_err = 0;
            prepare_line(cases[t]);
            stream_line(cases[t]);
            wait_line_end();
            check_line();
            report_test(t + 1);
        end

        $display("Tests: %0d passed, %0d failed, %0d errors", tests_pass, tests_fail, err_cnt);
        if (err_cnt == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

/* verilog.f */
src/env_pkg.sv
src/acq_if.sv
src/line_gate.sv
src/env_accum.sv
src/tag_sampler.sv
src/env_writer.sv
src/line_buffer.sv
src/env_capture_top.sv
test/env_capture_props.sv
test/env_capture_tb.sv
